/* common/hpm_cfg_if.sv */
`timescale 1ns/1ps

interface hpm_cfg_if;
  import hpm_pkg::*;

  // Configuration from the register block
  evt_sel_t             evt_sel [NUM_HPM];    // Entry k-1 belongs to counter k
  count_t               threshold [NUM_SLOTS];
  logic [NUM_SLOTS-1:0] inhibit;
  logic [NUM_SLOTS-1:0] sample_mask;
  logic [STORE_AW-1:0]  store_base;

  // Counter write request, one cycle
  logic                 cnt_we;
  slot_idx_t            cnt_idx;
  logic                 cnt_hi;       // Selects the upper half
  logic [APB_DW-1:0]    cnt_wdata;

  // Live counts, slot 0 is the cycle counter
  count_t               counts [NUM_SLOTS];

  modport regs (
    output evt_sel, threshold, inhibit, sample_mask, store_base,
    output cnt_we, cnt_idx, cnt_hi, cnt_wdata,
    input  counts
  );

  modport counters (
    input  evt_sel, inhibit, cnt_we, cnt_idx, cnt_hi, cnt_wdata,
    output counts
  );

  modport sampler (
    input threshold, sample_mask, store_base, counts
  );

endinterface

/* common/hpm_pkg.sv */
package hpm_pkg;

  // ----------------------------------------
  // Counter and sample sizing
  // ----------------------------------------
  localparam int unsigned CNT_W     = 64;
  localparam int unsigned NUM_HPM   = 6;
  localparam int unsigned NUM_SLOTS = 7;   // Slot 0 is the cycle counter

  typedef logic [2:0]       slot_idx_t;
  typedef logic [CNT_W-1:0] count_t;

  // ----------------------------------------
  // Events
  // ----------------------------------------
  localparam int unsigned NUM_EVENTS = 16;

  // Code k in 1..NUM_EVENTS counts event line k-1, anything else counts nothing
  typedef logic [4:0] evt_sel_t;

  // Event line indices
  localparam int unsigned EV_ICACHE_MISS = 0;
  localparam int unsigned EV_DCACHE_MISS = 1;
  localparam int unsigned EV_ITLB_MISS   = 2;
  localparam int unsigned EV_DTLB_MISS   = 3;
  localparam int unsigned EV_EXCEPTION   = 4;
  localparam int unsigned EV_ERET        = 5;
  localparam int unsigned EV_MISPREDICT  = 6;
  localparam int unsigned EV_SB_FULL     = 7;
  localparam int unsigned EV_IF_EMPTY    = 8;
  localparam int unsigned EV_STALL       = 9;
  localparam int unsigned EV_SPARE0      = 10;  // Lines 10..15 are spare
  localparam int unsigned EV_SPARE5      = 15;

  // ----------------------------------------
  // Bus and store port
  // ----------------------------------------
  localparam int unsigned APB_AW     = 12;
  localparam int unsigned APB_DW     = 32;
  localparam int unsigned STORE_AW   = 32;
  localparam int unsigned SLOT_BYTES = 8;   // Address stride of stored slots

  // ----------------------------------------
  // Register map, byte offsets
  // ----------------------------------------
  localparam logic [APB_AW-1:0] REG_CYCLE_LO   = 12'h000;
  localparam logic [APB_AW-1:0] REG_CYCLE_HI   = 12'h004;

  // Counter k at base + 8(k-1), lo then hi
  localparam logic [APB_AW-1:0] REG_CNT_BASE   = 12'h010;
  localparam logic [APB_AW-1:0] REG_CNT_END    = 12'h040;

  // Selector k at base + 4(k-1)
  localparam logic [APB_AW-1:0] REG_EVT_BASE   = 12'h040;
  localparam logic [APB_AW-1:0] REG_EVT_END    = 12'h058;

  // Threshold of slot s at base + 8s, lo then hi
  localparam logic [APB_AW-1:0] REG_THR_BASE   = 12'h060;
  localparam logic [APB_AW-1:0] REG_THR_END    = 12'h098;

  localparam logic [APB_AW-1:0] REG_INHIBIT    = 12'h0A0;
  localparam logic [APB_AW-1:0] REG_SAMPLE_CFG = 12'h0A4;
  localparam logic [APB_AW-1:0] REG_STORE_BASE = 12'h0A8;

endpackage

/* dv/hpm_tb.sv */
`timescale 1ns/1ps

module hpm_tb;
  import hpm_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int APB_TIMEOUT  = 16;
  localparam int STORE_LIMIT  = 400;   // Cycles allowed for one sampling pass
  localparam int QUIET        = 40;
  localparam int SAMPLE_N     = 4;
  localparam logic [31:0] STORE_BASE = 32'h8000_1000;

  logic                  clk_i, rst_ni;
  logic                  psel_i, penable_i, pwrite_i;
  logic [APB_AW-1:0]     paddr_i;
  logic [APB_DW-1:0]     pwdata_i, prdata_o;
  logic                  pready_o, pslverr_o;
  logic [NUM_EVENTS-1:0] event_i;
  logic                  debug_mode_i;
  logic                  store_req_o, store_ack_i;
  logic [STORE_AW-1:0]   store_addr_o;
  count_t                store_data_o;

  int          check_errors = 0;
  int          assert_errors = 0;
  int          timeouts = 0;
  logic [31:0] lcg_state = 32'h4fb6;
  logic [31:0] st_addr_q[$];          // Completed stores in order
  count_t      st_data_q[$];

  hpm_top uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  function logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [APB_AW-1:0] cnt_addr(input int k);
    return REG_CNT_BASE + APB_AW'(8 * (k - 1));
  endfunction

  function automatic logic [APB_AW-1:0] evt_addr(input int k);
    return REG_EVT_BASE + APB_AW'(4 * (k - 1));
  endfunction

  function automatic logic [APB_AW-1:0] thr_addr(input int s);
    return REG_THR_BASE + APB_AW'(8 * s);
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      check_errors++;
      $display("** Error at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
    end
  endtask

  // One APB transfer with setup and access phase
  task automatic apb_xfer(input logic wr, input logic [APB_AW-1:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
    int cycles;
    @(negedge clk_i);
    psel_i = 1'b1;
    penable_i = 1'b0;
    pwrite_i = wr;
    paddr_i = addr;
    pwdata_i = wdata;
    @(negedge clk_i);
    penable_i = 1'b1;
    cycles = 0;
    #1;
    while (!pready_o && cycles < APB_TIMEOUT) begin
      @(negedge clk_i);
      #1;
      cycles++;
    end
    if (!pready_o) begin
      timeouts++;
      $display("Timeout: pready_o never rose for address 0x%0h", addr);
    end
    rdata = prdata_o;
    err = pslverr_o;
    @(negedge clk_i);
    psel_i = 1'b0;
    penable_i = 1'b0;
    pwrite_i = 1'b0;
  endtask

  task automatic reg_write(input logic [APB_AW-1:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    logic        err;
    apb_xfer(1'b1, addr, data, unused, err);
    check_value($sformatf("pslverr_o on write 0x%0h", addr), 0, err);
  endtask

  task automatic reg_read_check(input logic [APB_AW-1:0] addr, input logic [31:0] exp);
    logic [31:0] data;
    logic        err;
    apb_xfer(1'b0, addr, '0, data, err);
    check_value($sformatf("prdata_o at 0x%0h", addr), exp, data);
    check_value($sformatf("pslverr_o on read 0x%0h", addr), 0, err);
  endtask

  task automatic read_counter(input int k, output logic [63:0] value);
    logic [31:0] lo, hi;
    logic        err;
    apb_xfer(1'b0, cnt_addr(k), '0, lo, err);
    apb_xfer(1'b0, cnt_addr(k) + 12'd4, '0, hi, err);
    value = {hi, lo};
  endtask

  task automatic pulse_events(input logic [NUM_EVENTS-1:0] lines, input int n);
    repeat (n) begin
      @(negedge clk_i);
      event_i = lines;
      @(negedge clk_i);
      event_i = '0;
    end
  endtask

  task automatic wait_stores(input int n, input string what);
    int cycles;
    cycles = 0;
    while (st_addr_q.size() < n && cycles < STORE_LIMIT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (st_addr_q.size() < n) begin
      timeouts++;
      $display("Timeout after %0d cycles waiting for %s", cycles, what);
    end
  endtask

  // Mask 0,1,3 gives three stores per pass
  task automatic check_pass(input int first, input logic [63:0] min_slot1);
    if (st_addr_q.size() < first + 3) begin
      check_errors++;
      $display("Only %0d stores seen, %0d were due", st_addr_q.size(), first + 3);
    end else begin
      check_value("store_addr_o slot 0", STORE_BASE, st_addr_q[first]);
      check_value("store_addr_o slot 1", STORE_BASE + 8, st_addr_q[first + 1]);
      check_value("store_addr_o slot 3", STORE_BASE + 24, st_addr_q[first + 2]);
      check_value("store_data_o slot 3", 0, st_data_q[first + 2]);
      assert (st_data_q[first + 1] >= min_slot1) else begin
        check_errors++;
        $display("** Error at %0t: store_data_o slot 1 expected >= 0x%0h, got 0x%0h",
                 $time, min_slot1, st_data_q[first + 1]);
      end
    end
  endtask

  // ----------------------------------------
  // Store port responder and monitor
  // ----------------------------------------
  always @(negedge clk_i) begin : ack_responder
    logic [31:0] rnd;
    logic [1:0]  ack_delay;
    logic        armed;
    store_ack_i = 1'b0;
    if (!rst_ni) begin
      armed = 1'b0;
    end else if (store_req_o) begin
      if (!armed) begin
        rnd = lcg_next();
        ack_delay = rnd[17:16];   // 0 to 3 cycles
        armed = 1'b1;
      end
      if (ack_delay == 2'd0) begin
        store_ack_i = 1'b1;
        armed = 1'b0;
      end else begin
        ack_delay--;
      end
    end
  end

  always @(posedge clk_i) begin
    if (rst_ni && store_req_o && store_ack_i) begin
      st_addr_q.push_back(store_addr_o);
      st_data_q.push_back(store_data_o);
    end
  end

  a_store_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    store_req_o && !store_ack_i |=>
      store_req_o && $stable(store_addr_o) && $stable(store_data_o))
    else begin
      assert_errors++;
      $display("Store request changed or dropped before its ack at %0t", $time);
    end

  a_no_wait : assert property (@(posedge clk_i) disable iff (!rst_ni)
    psel_i && penable_i |-> pready_o)
    else begin
      assert_errors++;
      $display("APB access phase without pready_o at %0t", $time);
    end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin : main
    logic [63:0] value;
    logic [31:0] rdata, cyc_a;
    logic        err;
    psel_i = 1'b0;
    penable_i = 1'b0;
    pwrite_i = 1'b0;
    paddr_i = '0;
    pwdata_i = '0;
    event_i = '0;
    debug_mode_i = 1'b0;
    store_ack_i = 1'b0;
    rst_ni = 1'b0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    check_value("store_req_o", 0, store_req_o);
    check_value("pslverr_o", 0, pslverr_o);
    check_value("prdata_o", 0, prdata_o);

    // Register read back with thresholds too large to fire
    for (int k = 1; k <= NUM_HPM; k++) reg_write(evt_addr(k), 32'(k + 9));
    for (int k = 1; k <= NUM_HPM; k++) reg_read_check(evt_addr(k), 32'(k + 9));
    for (int s = 0; s < NUM_SLOTS; s++) begin
      reg_write(thr_addr(s), 32'hA5A5_0000 + 32'(s));
      reg_write(thr_addr(s) + 12'd4, 32'h0000_0100 + 32'(s));
    end
    for (int s = 0; s < NUM_SLOTS; s++) begin
      reg_read_check(thr_addr(s), 32'hA5A5_0000 + 32'(s));
      reg_read_check(thr_addr(s) + 12'd4, 32'h0000_0100 + 32'(s));
    end
    for (int s = 0; s < NUM_SLOTS; s++) begin
      reg_write(thr_addr(s), '0);
      reg_write(thr_addr(s) + 12'd4, '0);
    end
    reg_write(REG_INHIBIT, 32'hFFFF_FFFF);
    reg_read_check(REG_INHIBIT, 32'h7F);    // Only 7 bits held
    reg_write(REG_SAMPLE_CFG, 32'h2A);
    reg_read_check(REG_SAMPLE_CFG, 32'h2A);
    reg_write(REG_STORE_BASE, STORE_BASE);
    reg_read_check(REG_STORE_BASE, STORE_BASE);
    apb_xfer(1'b0, 12'h0B0, '0, rdata, err);
    check_value("pslverr_o on unmapped read", 1, err);
    apb_xfer(1'b1, REG_CYCLE_LO, 32'h1234, rdata, err);
    check_value("pslverr_o on cycle write", 1, err);

    // Event counting with counter 4 inhibited
    for (int k = 1; k <= NUM_HPM; k++) reg_write(evt_addr(k), '0);
    reg_write(evt_addr(2), EV_DCACHE_MISS + 1);
    reg_write(evt_addr(4), EV_STALL + 1);
    reg_write(REG_INHIBIT, 32'h10);
    pulse_events('1, 5);
    pulse_events(~(NUM_EVENTS'(1) << EV_DCACHE_MISS), 2);  // Every line but counter 2's
    read_counter(2, value);
    check_value("counter 2", 5, value);
    read_counter(3, value);
    check_value("counter 3", 0, value);
    read_counter(4, value);
    check_value("counter 4", 0, value);

    @(negedge clk_i);
    debug_mode_i = 1'b1;
    apb_xfer(1'b0, REG_CYCLE_LO, '0, cyc_a, err);
    pulse_events('1, 4);
    apb_xfer(1'b0, REG_CYCLE_LO, '0, rdata, err);
    check_value("cycle count in debug", cyc_a, rdata);
    read_counter(2, value);
    check_value("counter 2 in debug", 5, value);
    @(negedge clk_i);
    debug_mode_i = 1'b0;

    // Carry from the low half
    reg_write(cnt_addr(1) + 12'd4, '0);
    reg_write(cnt_addr(1), 32'hFFFF_FFFE);
    read_counter(1, value);
    check_value("counter 1 after write", 64'hFFFF_FFFE, value);
    reg_write(evt_addr(1), EV_ICACHE_MISS + 1);
    pulse_events(NUM_EVENTS'(1) << EV_ICACHE_MISS, 3);
    read_counter(1, value);
    check_value("counter 1 after carry", 64'h1_0000_0001, value);

    // First sampling pass
    reg_write(cnt_addr(1) + 12'd4, '0);
    reg_write(cnt_addr(1), '0);
    reg_write(REG_SAMPLE_CFG, 32'h0B);
    st_addr_q.delete();
    st_data_q.delete();
    reg_write(thr_addr(1), SAMPLE_N);
    pulse_events(NUM_EVENTS'(1) << EV_ICACHE_MISS, SAMPLE_N);
    wait_stores(3, "first sampling pass");
    repeat (QUIET) @(negedge clk_i);
    check_value("store count after first pass", 3, st_addr_q.size());
    check_pass(0, SAMPLE_N);

    // Offset rearmed at the snapshot so one count short stays quiet
    pulse_events(NUM_EVENTS'(1) << EV_ICACHE_MISS, SAMPLE_N - 1);
    repeat (QUIET) @(negedge clk_i);
    check_value("store count before rearm", 3, st_addr_q.size());
    pulse_events(NUM_EVENTS'(1) << EV_ICACHE_MISS, 1);
    wait_stores(6, "second sampling pass");
    repeat (QUIET) @(negedge clk_i);
    check_value("store count after second pass", 6, st_addr_q.size());
    check_pass(3, 2 * SAMPLE_N);

    $display("Errors: %0d check, %0d assertion, %0d timeout",
             check_errors, assert_errors, timeouts);
    if (check_errors + assert_errors + timeouts == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* hw/counters/hpm_event_counters.sv */
`timescale 1ns/1ps

module hpm_event_counters (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic [hpm_pkg::NUM_EVENTS-1:0] event_i,
  input  logic                           debug_mode_i,
  hpm_cfg_if.counters                    cfg
);
  import hpm_pkg::*;

  logic [NUM_SLOTS-1:0] inc;    // Raw increment per slot
  logic [NUM_SLOTS-1:0] run;    // Increment after inhibit and debug hold
  logic [NUM_SLOTS-1:0] wr_sel;
  count_t               cnt_q [NUM_SLOTS];

  // ----------------------------------------
  // Event selection
  // ----------------------------------------
  always_comb begin : evt_mux
    evt_sel_t sel;
    inc[0] = 1'b1;  // Cycle counter
    for (int k = 1; k < NUM_SLOTS; k++) begin
      sel = cfg.evt_sel[k-1];
      if (sel != '0 && sel <= evt_sel_t'(NUM_EVENTS)) begin
        inc[k] = event_i[4'(sel - 5'd1)];
      end else begin
        inc[k] = 1'b0;
      end
    end
  end

  // Debug mode freezes every slot, cycle counter included
  assign run = inc & ~cfg.inhibit & {NUM_SLOTS{~debug_mode_i}};

  always_comb begin
    wr_sel[0] = 1'b0;  // Cycle counter is not writable
    for (int k = 1; k < NUM_SLOTS; k++) begin
      wr_sel[k] = cfg.cnt_we && (cfg.cnt_idx == slot_idx_t'(k));
    end
  end

  // ----------------------------------------
  // Counters
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '{default: '0};
    end else begin
      for (int k = 0; k < NUM_SLOTS; k++) begin
        if (wr_sel[k]) begin
          // Write wins over a same-cycle increment
          if (cfg.cnt_hi) cnt_q[k][CNT_W-1:APB_DW] <= cfg.cnt_wdata;
          else            cnt_q[k][APB_DW-1:0]     <= cfg.cnt_wdata;
        end else if (run[k]) begin
          cnt_q[k] <= cnt_q[k] + 1'b1;
        end
      end
    end
  end

  assign cfg.counts = cnt_q;

  // Register decode must only ever address counters 1..NUM_HPM
  a_cnt_idx_range : assert property (@(posedge clk_i) disable iff (!rst_ni)
    cfg.cnt_we |-> (cfg.cnt_idx != '0) && (cfg.cnt_idx <= slot_idx_t'(NUM_HPM)))
    else $error("Counter write to index %0d", cfg.cnt_idx);

endmodule

/* hw/hpm_apb_regs.sv */
`timescale 1ns/1ps

module hpm_apb_regs (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       psel_i,
  input  logic                       penable_i,
  input  logic                       pwrite_i,
  input  logic [hpm_pkg::APB_AW-1:0] paddr_i,
  input  logic [hpm_pkg::APB_DW-1:0] pwdata_i,
  output logic [hpm_pkg::APB_DW-1:0] prdata_o,
  output logic                       pready_o,
  output logic                       pslverr_o,
  hpm_cfg_if.regs                    cfg
);
  import hpm_pkg::*;

  logic                 acc;
  logic                 wr;
  logic                 aligned;
  logic                 hit_cycle, hit_cnt, hit_evt, hit_thr;
  logic                 hit_inh, hit_smp, hit_base;
  logic                 mapped;
  logic [APB_AW-1:0]    cnt_off, evt_off, thr_off;
  slot_idx_t            cnt_sel;      // Counter number 1..6
  logic [2:0]           evt_sel_idx;
  slot_idx_t            thr_sel;
  logic                 hi_half;
  logic [APB_DW-1:0]    rdata;

  evt_sel_t             evt_sel_q [NUM_HPM];
  count_t               thr_q [NUM_SLOTS];
  logic [NUM_SLOTS-1:0] inhibit_q;
  logic [NUM_SLOTS-1:0] sample_mask_q;
  logic [STORE_AW-1:0]  store_base_q;

  assign acc = psel_i & penable_i;     // Access phase, no wait states
  assign wr  = acc & pwrite_i;

  // ----------------------------------------
  // Address decode
  // ----------------------------------------
  assign aligned  = (paddr_i[1:0] == 2'b00);
  assign hi_half  = paddr_i[2];
  assign cnt_off  = paddr_i - REG_CNT_BASE;
  assign evt_off  = paddr_i - REG_EVT_BASE;
  assign thr_off  = paddr_i - REG_THR_BASE;

  assign cnt_sel     = cnt_off[5:3] + 3'd1;
  assign evt_sel_idx = evt_off[4:2];
  assign thr_sel     = thr_off[5:3];

  assign hit_cycle = aligned && (paddr_i == REG_CYCLE_LO || paddr_i == REG_CYCLE_HI);
  assign hit_cnt   = aligned && (paddr_i >= REG_CNT_BASE) && (paddr_i < REG_CNT_END);
  assign hit_evt   = aligned && (paddr_i >= REG_EVT_BASE) && (paddr_i < REG_EVT_END);
  assign hit_thr   = aligned && (paddr_i >= REG_THR_BASE) && (paddr_i < REG_THR_END);
  assign hit_inh   = (paddr_i == REG_INHIBIT);
  assign hit_smp   = (paddr_i == REG_SAMPLE_CFG);
  assign hit_base  = (paddr_i == REG_STORE_BASE);

  assign mapped = hit_cycle | hit_cnt | hit_evt | hit_thr | hit_inh | hit_smp | hit_base;

  // ----------------------------------------
  // Configuration registers
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      evt_sel_q     <= '{default: '0};
      thr_q         <= '{default: '0};
      inhibit_q     <= '0;
      sample_mask_q <= '0;
      store_base_q  <= '0;
    end else if (wr) begin
      if (hit_evt) evt_sel_q[evt_sel_idx] <= pwdata_i[4:0];
      if (hit_thr) begin
        if (hi_half) thr_q[thr_sel][CNT_W-1:APB_DW] <= pwdata_i;
        else         thr_q[thr_sel][APB_DW-1:0]     <= pwdata_i;
      end
      if (hit_inh)  inhibit_q     <= pwdata_i[NUM_SLOTS-1:0];
      if (hit_smp)  sample_mask_q <= pwdata_i[NUM_SLOTS-1:0];
      if (hit_base) store_base_q  <= pwdata_i;
    end
  end

  assign cfg.evt_sel     = evt_sel_q;
  assign cfg.threshold   = thr_q;
  assign cfg.inhibit     = inhibit_q;
  assign cfg.sample_mask = sample_mask_q;
  assign cfg.store_base  = store_base_q;

  // Counters live in the counter block, writes land at the end of the access phase
  assign cfg.cnt_we    = wr & hit_cnt;
  assign cfg.cnt_idx   = cnt_sel;
  assign cfg.cnt_hi    = hi_half;
  assign cfg.cnt_wdata = pwdata_i;

  // ----------------------------------------
  // Read path
  // ----------------------------------------
  always_comb begin
    rdata = '0;
    if (hit_cycle) begin
      rdata = hi_half ? cfg.counts[0][CNT_W-1:APB_DW] : cfg.counts[0][APB_DW-1:0];
    end else if (hit_cnt) begin
      rdata = hi_half ? cfg.counts[cnt_sel][CNT_W-1:APB_DW] : cfg.counts[cnt_sel][APB_DW-1:0];
    end else if (hit_evt) begin
      rdata = APB_DW'(evt_sel_q[evt_sel_idx]);
    end else if (hit_thr) begin
      rdata = hi_half ? thr_q[thr_sel][CNT_W-1:APB_DW] : thr_q[thr_sel][APB_DW-1:0];
    end else if (hit_inh) begin
      rdata = APB_DW'(inhibit_q);
    end else if (hit_smp) begin
      rdata = APB_DW'(sample_mask_q);
    end else if (hit_base) begin
      rdata = store_base_q;
    end
  end

  assign prdata_o  = (acc && !pwrite_i) ? rdata : '0;
  assign pready_o  = 1'b1;
  assign pslverr_o = acc & (~mapped | (pwrite_i & hit_cycle));  // Cycle counter is read only

  // Error only in an access phase that follows its setup phase
  a_slverr_access : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pslverr_o |-> penable_i && $past(psel_i && !penable_i))
    else $error("pslverr_o outside an APB access phase");

endmodule

/* hw/hpm_top.sv */
`timescale 1ns/1ps

module hpm_top (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // APB slave
  input  logic                           psel_i,
  input  logic                           penable_i,
  input  logic                           pwrite_i,
  input  logic [hpm_pkg::APB_AW-1:0]     paddr_i,
  input  logic [hpm_pkg::APB_DW-1:0]     pwdata_i,
  output logic [hpm_pkg::APB_DW-1:0]     prdata_o,
  output logic                           pready_o,
  output logic                           pslverr_o,
  // Monitored events
  input  logic [hpm_pkg::NUM_EVENTS-1:0] event_i,
  input  logic                           debug_mode_i,
  // Sample store port
  output logic                           store_req_o,
  output logic [hpm_pkg::STORE_AW-1:0]   store_addr_o,
  output hpm_pkg::count_t                store_data_o,
  input  logic                           store_ack_i
);

  hpm_cfg_if cfg_if ();

  hpm_apb_regs u_regs (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .cfg       (cfg_if.regs)
  );

  hpm_event_counters u_counters (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .event_i      (event_i),
    .debug_mode_i (debug_mode_i),
    .cfg          (cfg_if.counters)
  );

  hpm_sampler u_sampler (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .store_ack_i  (store_ack_i),
    .cfg          (cfg_if.sampler),
    .store_req_o  (store_req_o),
    .store_addr_o (store_addr_o),
    .store_data_o (store_data_o)
  );

endmodule

/* hw/sampler/hpm_sampler.sv */
`timescale 1ns/1ps

module hpm_sampler (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         store_ack_i,
  hpm_cfg_if.sampler                   cfg,
  output logic                         store_req_o,
  output logic [hpm_pkg::STORE_AW-1:0] store_addr_o,
  output hpm_pkg::count_t              store_data_o
);
  import hpm_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    SAMPLING,
    STORE_WAIT
  } state_e;

  state_e               state_q;
  slot_idx_t            idx_q;
  count_t               off_q [NUM_SLOTS];   // Count at the last trigger per slot
  count_t               snap_q [NUM_SLOTS];
  logic [STORE_AW-1:0]  base_q;
  logic [NUM_SLOTS-1:0] hit;
  logic                 trigger;
  logic                 walking;
  logic                 slot_done;
  logic                 last_slot;

  // ----------------------------------------
  // Threshold monitor
  // ----------------------------------------
  always_comb begin
    for (int s = 0; s < NUM_SLOTS; s++) begin
      hit[s] = (cfg.threshold[s] != '0) &&
               (cfg.counts[s] >= off_q[s] + cfg.threshold[s]);
    end
  end

  assign trigger = (state_q == IDLE) && (|hit);

  // ----------------------------------------
  // Store port
  // ----------------------------------------
  assign walking     = (state_q == SAMPLING) || (state_q == STORE_WAIT);
  assign store_req_o = ((state_q == SAMPLING) && cfg.sample_mask[idx_q]) ||
                       (state_q == STORE_WAIT);
  assign slot_done   = walking && (!store_req_o || store_ack_i);   // Skip or ack
  assign last_slot   = (idx_q == slot_idx_t'(NUM_SLOTS - 1));

  assign store_addr_o = base_q + STORE_AW'(idx_q) * STORE_AW'(SLOT_BYTES);
  assign store_data_o = snap_q[idx_q];

  // ----------------------------------------
  // Sequencer
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      idx_q   <= '0;
      off_q   <= '{default: '0};
    end else begin
      unique case (state_q)
        IDLE: begin
          if (trigger) begin
            state_q <= SAMPLING;
            idx_q   <= '0;
            for (int s = 0; s < NUM_SLOTS; s++) begin
              if (hit[s]) off_q[s] <= cfg.counts[s];  // Rearm from current count
            end
          end
        end
        SAMPLING, STORE_WAIT: begin
          if (slot_done) begin
            if (last_slot) begin
              state_q <= IDLE;
              idx_q   <= '0;
            end else begin
              state_q <= SAMPLING;
              idx_q   <= idx_q + 3'd1;
            end
          end else begin
            state_q <= STORE_WAIT;  // Request pending without ack
          end
        end
        default: begin
          state_q <= IDLE;
          idx_q   <= '0;
        end
      endcase
    end
  end

  // Snapshot and base are taken together so a walk stores one consistent set
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      snap_q <= '{default: '0};
      base_q <= '0;
    end else if (trigger) begin
      snap_q <= cfg.counts;
      base_q <= cfg.store_base;
    end
  end

  a_req_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    store_req_o && !store_ack_i |=>
      store_req_o && $stable(store_addr_o) && $stable(store_data_o))
    else $error("Store request changed before ack");

endmodule

/* sources.f */
common/hpm_pkg.sv
common/hpm_cfg_if.sv
hw/hpm_apb_regs.sv
hw/counters/hpm_event_counters.sv
hw/sampler/hpm_sampler.sv
hw/hpm_top.sv
dv/hpm_tb.sv
